// ==== all.f ====
+incdir+include
hw/audio_mix_pkg.sv
hw/mix_if.sv
hw/mix_regs.sv
hw/sample_capture.sv
hw/channel_mixer.sv
hw/stereo_output.sv
hw/audio_mix_top.sv
sim/tb_audio_mix.sv

// ==== sim/tb_audio_mix.sv ====
//================================================
// Audio mixer testbench
// Directed tests of the APB control register and
// the sample path through audio_mix_top
//================================================
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_config.svh"

module tb_audio_mix;
	import audio_mix_pkg::*;

	// About 200 cycles of tests, limit set well above
	localparam int TIMEOUT_CYCLES = 2000;
	localparam int LAT = 4;
	localparam int OUT_MAX = (1 <<< (`AM_OUT_W - 1)) - 1;
	localparam int OUT_MIN = -(1 <<< (`AM_OUT_W - 1));

	logic                         clk_sys;
	logic                         reset_n;
	logic                         psel_i;
	logic                         penable_i;
	logic                         pwrite_i;
	logic [`AM_APB_AW-1:0]        paddr_i;
	logic [`AM_DATA_W-1:0]        pwdata_i;
	logic [`AM_DATA_W-1:0]        prdata_o;
	logic                         pready_o;
	logic                         pslverr_o;
	logic                         sample_valid_i;
	logic signed [`AM_SID_W-1:0]  sid_l_i;
	logic signed [`AM_SID_W-1:0]  sid_r6581_i;
	logic signed [`AM_SID_W-1:0]  sid_r8580_i;
	logic signed [`AM_OPL_W-1:0]  opl_i;
	logic                         cass_i;
	logic                         sample_valid_o;
	logic signed [`AM_OUT_W-1:0]  audio_l_o;
	logic signed [`AM_OUT_W-1:0]  audio_r_o;

	int        seed = 85404;
	int        cycle_cnt = 0;
	int        err_cnt = 0;
	int        check_cnt = 0;
	int        test_cnt = 0;
	int        test_err_start;
	mix_ctrl_u cur_ctrl;
	int        due_q[$];
	int        exp_l_q[$];
	int        exp_r_q[$];

	audio_mix_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, output samples still pending", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

	//================================================
	// Compare tasks and reference model
	//================================================
	task automatic report_error(input string msg);
		err_cnt++;
		$display("Error at cycle %0d: %s", cycle_cnt, msg);
	endtask

	task automatic check_word(input string name, input mix_ctrl_u got, input mix_ctrl_u exp);
		check_cnt++;
		if (got.raw !== exp.raw) begin
			err_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got.raw, exp.raw);
		end
	endtask

	task automatic check_sample(input string name, input logic signed [`AM_OUT_W-1:0] got,
		input logic signed [`AM_OUT_W-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// Rounds toward minus infinity like an arithmetic shift
	function automatic int div_floor(input int x, input int d);
		if (x >= 0)
			return x / d;
		return -((-x + d - 1) / d);
	endfunction

	function automatic int chan_ref(input int sid, input int opl, input logic cass);
		int s;
		s = div_floor(sid, 4);
		if (cur_ctrl.f.opl_en)
			s += opl;
		if (cur_ctrl.f.tape_snd_en && cass)
			s += `AM_TAPE_LEVEL;
		if (s > OUT_MAX)
			s = OUT_MAX;
		else if (s < OUT_MIN)
			s = OUT_MIN;
		return s;
	endfunction

	function automatic logic signed [`AM_SID_W-1:0] rand_sid();
		logic [31:0] rv;
		rv = $random(seed);
		return rv[`AM_SID_W-1:0];
	endfunction

	// Narrow range keeps SID + FM + tape inside the 17-bit sum
	function automatic logic signed [`AM_OPL_W-1:0] rand_opl(input bit narrow);
		logic [31:0] rv;
		rv = $random(seed);
		if (narrow)
			return {{3{rv[12]}}, rv[12:0]};
		return rv[`AM_OPL_W-1:0];
	endfunction

	//================================================
	// Bus and sample drivers
	//================================================
	task automatic apb_xfer(input logic wr, input logic [`AM_APB_AW-1:0] addr,
		input logic [`AM_DATA_W-1:0] wdata, output logic [`AM_DATA_W-1:0] rdata,
		output logic err);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = wr;
		paddr_i   = addr;
		pwdata_i  = wdata;
		@(negedge clk_sys);
		penable_i = 1'b1;
		@(posedge clk_sys);
		rdata = prdata_o;
		err   = pslverr_o;
		check_flag("pready_o", pready_o, 1'b1);
		@(negedge clk_sys);
		psel_i    = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic write_ctrl(input logic [`AM_DATA_W-1:0] data);
		logic [`AM_DATA_W-1:0] rd;
		logic                  err;
		apb_xfer(1'b1, `AM_REG_CTRL, data, rd, err);
		check_flag("pslverr_o", err, 1'b0);
		cur_ctrl.raw = data & 32'h0000_001F;
	endtask

	task automatic send_sample(input logic signed [`AM_SID_W-1:0] sl,
		input logic signed [`AM_SID_W-1:0] s6581, input logic signed [`AM_SID_W-1:0] s8580,
		input logic signed [`AM_OPL_W-1:0] opl, input logic cass);
		int l;
		int r;
		sample_valid_i = 1'b1;
		sid_l_i        = sl;
		sid_r6581_i    = s6581;
		sid_r8580_i    = s8580;
		opl_i          = opl;
		cass_i         = cass;
		l = chan_ref(sl, opl, cass);
		r = chan_ref(cur_ctrl.f.right_sid_8580 ? s8580 : s6581, opl, cass);
		due_q.push_back(cycle_cnt + LAT);
		case (cur_ctrl.f.stereo_mix)
			MIX_25: begin
				exp_l_q.push_back(l - div_floor(l, 4) + div_floor(r, 4));
				exp_r_q.push_back(r - div_floor(r, 4) + div_floor(l, 4));
			end
			MIX_50, MIX_MONO: begin
				exp_l_q.push_back(div_floor(l + r, 2));
				exp_r_q.push_back(div_floor(l + r, 2));
			end
			default: begin
				exp_l_q.push_back(l);
				exp_r_q.push_back(r);
			end
		endcase
		@(negedge clk_sys);
	endtask

	task automatic drain();
		sample_valid_i = 1'b0;
		while (due_q.size() != 0)
			@(negedge clk_sys);
		@(negedge clk_sys);
	endtask

	// Output side, stable at the falling edge
	always @(negedge clk_sys) begin : monitor
		int due;
		if (reset_n) begin
			if (sample_valid_o === 1'b1) begin
				if (due_q.size() == 0) begin
					report_error("output sample appeared with no input pending");
				end else begin
					due = due_q.pop_front();
					if (due != cycle_cnt)
						report_error($sformatf("output sample due at cycle %0d", due));
					check_sample("audio_l_o", audio_l_o, exp_l_q.pop_front());
					check_sample("audio_r_o", audio_r_o, exp_r_q.pop_front());
				end
			end else if (due_q.size() != 0 && due_q[0] <= cycle_cnt) begin
				report_error("expected output sample did not arrive");
				due = due_q.pop_front();
				due = exp_l_q.pop_front();
				due = exp_r_q.pop_front();
			end
		end
	end

	task automatic start_test();
		test_cnt++;
		test_err_start = err_cnt;
	endtask

	task automatic end_test(input string name);
		$display("Test %0d %s done with %0d errors", test_cnt, name, err_cnt - test_err_start);
	endtask

	//================================================
	// Directed tests
	//================================================
	task automatic test_regs();
		logic [`AM_DATA_W-1:0] rd;
		logic                  err;
		mix_ctrl_u             exp;
		start_test();
		check_flag("sample_valid_o", sample_valid_o, 1'b0);
		apb_xfer(1'b0, `AM_REG_CTRL, '0, rd, err);
		exp.raw = '0;
		check_word("prdata_o", rd, exp);
		check_flag("pslverr_o", err, 1'b0);
		write_ctrl('1);
		apb_xfer(1'b0, `AM_REG_CTRL, '0, rd, err);
		exp.raw = 32'h1F;
		check_word("prdata_o", rd, exp);
		apb_xfer(1'b0, 4'h8, '0, rd, err);
		check_flag("pslverr_o", err, 1'b1);
		exp.raw = '0;
		check_word("prdata_o", rd, exp);
		// Unmapped write leaves CTRL alone
		apb_xfer(1'b1, 4'h8, 32'h0, rd, err);
		check_flag("pslverr_o", err, 1'b1);
		apb_xfer(1'b0, `AM_REG_CTRL, '0, rd, err);
		exp.raw = 32'h1F;
		check_word("prdata_o", rd, exp);
		write_ctrl(32'h0);
		end_test("reset and registers");
	endtask

	task automatic test_plain();
		start_test();
		repeat (20)
			send_sample(rand_sid(), rand_sid(), rand_sid(), rand_opl(1'b0), 1'b1);
		drain();
		end_test("plain mix");
	endtask

	task automatic test_fm_tape();
		logic [31:0] rv;
		start_test();
		write_ctrl(32'h7);
		repeat (20) begin
			rv = $random(seed);
			send_sample(rand_sid(), rand_sid(), rand_sid(), rand_opl(1'b1), rv[0]);
		end
		drain();
		end_test("fm, tape and right sid select");
	endtask

	task automatic test_saturation();
		start_test();
		write_ctrl(32'h1);
		send_sample(18'sh1FFFF, 18'sh1FFFF, 18'sh1FFFF, 16'sh7FFF, 1'b0);
		send_sample(-18'sh20000, -18'sh20000, -18'sh20000, -16'sh8000, 1'b0);
		send_sample(18'sh10000, -18'sh10000, 18'sh0, 16'sh7000, 1'b1);
		drain();
		end_test("saturation");
	endtask

	task automatic test_stereo();
		stereo_mode_t modes [3];
		start_test();
		modes = '{MIX_25, MIX_50, MIX_MONO};
		foreach (modes[i]) begin
			write_ctrl({27'd0, modes[i], 3'b001});
			repeat (10)
				send_sample(rand_sid(), rand_sid(), rand_sid(), rand_opl(1'b0), 1'b0);
			drain();
		end
		end_test("stereo modes");
	endtask

	initial begin
		reset_n        = 1'b0;
		psel_i         = 1'b0;
		penable_i      = 1'b0;
		pwrite_i       = 1'b0;
		paddr_i        = '0;
		pwdata_i       = '0;
		sample_valid_i = 1'b0;
		sid_l_i        = '0;
		sid_r6581_i    = '0;
		sid_r8580_i    = '0;
		opl_i          = '0;
		cass_i         = 1'b0;
		cur_ctrl.raw   = '0;
		repeat (3) @(negedge clk_sys);
		reset_n = 1'b1;
		test_regs();
		test_plain();
		test_fm_tape();
		test_saturation();
		test_stereo();
		$display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/audio_mix_top.sv ====
//================================================
// Audio mixer top level
// APB control, sample capture, two channel mixers
// and the stereo output stage
//================================================
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_config.svh"

module audio_mix_top (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	// APB slave
	input  wire                         psel_i,
	input  wire                         penable_i,
	input  wire                         pwrite_i,
	input  wire [`AM_APB_AW-1:0]        paddr_i,
	input  wire [`AM_DATA_W-1:0]        pwdata_i,
	output logic [`AM_DATA_W-1:0]       prdata_o,
	output logic                        pready_o,
	output logic                        pslverr_o,
	// Sample inputs
	input  wire                         sample_valid_i,
	input  wire signed [`AM_SID_W-1:0]  sid_l_i,
	input  wire signed [`AM_SID_W-1:0]  sid_r6581_i,
	input  wire signed [`AM_SID_W-1:0]  sid_r8580_i,
	input  wire signed [`AM_OPL_W-1:0]  opl_i,
	input  wire                         cass_i,
	// DAC side
	output logic                        sample_valid_o,
	output logic signed [`AM_OUT_W-1:0] audio_l_o,
	output logic signed [`AM_OUT_W-1:0] audio_r_o
);

	logic [`AM_NUM_CH-1:0]        chan_valid;
	logic signed [`AM_OUT_W-1:0]  chan_mix [`AM_NUM_CH];

	mix_cfg_if     cfg_if ();
	chan_sample_if smp_if [`AM_NUM_CH] ();

	mix_regs u_regs (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.cfg       (cfg_if.regs)
	);

	sample_capture u_capture (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.sample_valid_i (sample_valid_i),
		.sid_l_i        (sid_l_i),
		.sid_r6581_i    (sid_r6581_i),
		.sid_r8580_i    (sid_r8580_i),
		.opl_i          (opl_i),
		.cass_i         (cass_i),
		.cfg            (cfg_if.cap),
		.ch             (smp_if)
	);

	// One mixer per channel, 0 is left
	for (genvar g = 0; g < `AM_NUM_CH; g++) begin : g_chan
		channel_mixer u_mixer (
			.clk_sys (clk_sys),
			.reset_n (reset_n),
			.smp     (smp_if[g]),
			.cfg     (cfg_if.chan),
			.valid_o (chan_valid[g]),
			.mix_o   (chan_mix[g])
		);
	end

	stereo_output u_out (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.valid_i        (chan_valid),
		.mix_l_i        (chan_mix[0]),
		.mix_r_i        (chan_mix[1]),
		.cfg            (cfg_if.out),
		.sample_valid_o (sample_valid_o),
		.audio_l_o      (audio_l_o),
		.audio_r_o      (audio_r_o)
	);

endmodule

`default_nettype wire

// ==== hw/stereo_output.sv ====
//================================================
// Stereo output stage
// Blends left and right by the selected stereo
// mode and registers the final DAC samples
//================================================
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_config.svh"

module stereo_output (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	input  wire [`AM_NUM_CH-1:0]        valid_i,
	input  wire signed [`AM_OUT_W-1:0]  mix_l_i,
	input  wire signed [`AM_OUT_W-1:0]  mix_r_i,
	mix_cfg_if.out                      cfg,
	output logic                        sample_valid_o,
	output logic signed [`AM_OUT_W-1:0] audio_l_o,
	output logic signed [`AM_OUT_W-1:0] audio_r_o
);
	import audio_mix_pkg::*;

	localparam int EXT_W = `AM_OUT_W + 1;

	logic signed [EXT_W-1:0] l_ext;
	logic signed [EXT_W-1:0] r_ext;
	logic signed [EXT_W-1:0] l_25;
	logic signed [EXT_W-1:0] r_25;
	logic signed [EXT_W-1:0] avg;
	logic signed [EXT_W-1:0] l_blend;
	logic signed [EXT_W-1:0] r_blend;

	assign l_ext = {mix_l_i[`AM_OUT_W-1], mix_l_i};
	assign r_ext = {mix_r_i[`AM_OUT_W-1], mix_r_i};

	// Quarter crossfeed, three quarters own plus one quarter other
	assign l_25 = l_ext - (l_ext >>> 2) + (r_ext >>> 2);
	assign r_25 = r_ext - (r_ext >>> 2) + (l_ext >>> 2);
	assign avg  = (l_ext + r_ext) >>> 1;

	//================================================
	// Mode select
	//================================================
	always_comb begin
		case (cfg.stereo_mix)
			MIX_25: begin
				l_blend = l_25;
				r_blend = r_25;
			end
			// Half and full mix both land on the average
			MIX_50, MIX_MONO: begin
				l_blend = avg;
				r_blend = avg;
			end
			default: begin
				l_blend = l_ext;
				r_blend = r_ext;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			sample_valid_o <= 1'b0;
		end else begin
			sample_valid_o <= valid_i[0];
		end
	end

	always_ff @(posedge clk_sys) begin
		audio_l_o <= l_blend[`AM_OUT_W-1:0];
		audio_r_o <= r_blend[`AM_OUT_W-1:0];
	end

endmodule

`default_nettype wire

// ==== hw/channel_mixer.sv ====
//================================================
// Channel mixer
// Sums SID, FM and tape for one channel, then
// saturates to a signed output sample
//================================================
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_config.svh"

module channel_mixer (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	chan_sample_if.dst                  smp,
	mix_cfg_if.chan                     cfg,
	output logic                        valid_o,
	output logic signed [`AM_OUT_W-1:0] mix_o
);

	localparam int SUM_W = `AM_OUT_W + 1;
	localparam logic signed [SUM_W-1:0] OUT_MAX = 2 ** (`AM_OUT_W - 1) - 1;
	localparam logic signed [SUM_W-1:0] OUT_MIN = -(2 ** (`AM_OUT_W - 1));

	logic signed [`AM_SID_W-1:0] sid_sh;
	logic signed [SUM_W-1:0]     sid_term;
	logic signed [SUM_W-1:0]     opl_term;
	logic signed [SUM_W-1:0]     tape_term;
	logic signed [SUM_W-1:0]     sum_q;
	logic                        valid_s1;

	// SID drops two LSBs, upper bits are sign copies
	assign sid_sh    = smp.sid >>> 2;
	assign sid_term  = sid_sh[SUM_W-1:0];
	assign opl_term  = cfg.opl_en ? {smp.opl[`AM_OPL_W-1], smp.opl} : '0;
	assign tape_term = (cfg.tape_snd_en && smp.cass) ? SUM_W'(`AM_TAPE_LEVEL) : '0;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			valid_s1 <= 1'b0;
			valid_o  <= 1'b0;
		end else begin
			valid_s1 <= smp.valid;
			valid_o  <= valid_s1;
		end
	end

	// Stage one, raw sum
	always_ff @(posedge clk_sys) begin
		sum_q <= sid_term + opl_term + tape_term;
	end

	// Stage two, clamp to the output range
	always_ff @(posedge clk_sys) begin
		if (sum_q > OUT_MAX) begin
			mix_o <= OUT_MAX[`AM_OUT_W-1:0];
		end else if (sum_q < OUT_MIN) begin
			mix_o <= OUT_MIN[`AM_OUT_W-1:0];
		end else begin
			mix_o <= sum_q[`AM_OUT_W-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/sample_capture.sv ====
//================================================
// Sample capture
// Registers the input samples, picks the right SID
// model and fans the set out to both channels
//================================================
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_config.svh"

module sample_capture (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	input  wire                         sample_valid_i,
	input  wire signed [`AM_SID_W-1:0]  sid_l_i,
	input  wire signed [`AM_SID_W-1:0]  sid_r6581_i,
	input  wire signed [`AM_SID_W-1:0]  sid_r8580_i,
	input  wire signed [`AM_OPL_W-1:0]  opl_i,
	input  wire                         cass_i,
	mix_cfg_if.cap                      cfg,
	chan_sample_if.src                  ch [`AM_NUM_CH]
);

	logic                        valid_q;
	logic signed [`AM_SID_W-1:0] sid_q [`AM_NUM_CH];
	logic signed [`AM_OPL_W-1:0] opl_q;
	logic                        cass_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= sample_valid_i;
		end
	end

	// Payload, index 0 is left and index 1 is right
	always_ff @(posedge clk_sys) begin
		sid_q[0] <= sid_l_i;
		sid_q[1] <= cfg.right_sid_8580 ? sid_r8580_i : sid_r6581_i;
		opl_q    <= opl_i;
		cass_q   <= cass_i;
	end

	// FM and tape are shared by both channels
	for (genvar g = 0; g < `AM_NUM_CH; g++) begin : g_fanout
		assign ch[g].valid = valid_q;
		assign ch[g].sid   = sid_q[g];
		assign ch[g].opl   = opl_q;
		assign ch[g].cass  = cass_q;
	end

endmodule

`default_nettype wire

// ==== hw/mix_regs.sv ====
//================================================
// Mixer control registers
// APB slave with one CTRL word, no wait states,
// error response on unmapped addresses
//================================================
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_config.svh"

module mix_regs (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   psel_i,
	input  wire                   penable_i,
	input  wire                   pwrite_i,
	input  wire [`AM_APB_AW-1:0]  paddr_i,
	input  wire [`AM_DATA_W-1:0]  pwdata_i,
	output logic [`AM_DATA_W-1:0] prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	mix_cfg_if.regs               cfg
);
	import audio_mix_pkg::*;

	mix_ctrl_u ctrl_q;
	mix_ctrl_u wr_word;
	logic      access;
	logic      ctrl_hit;

	// Access phase of an APB transfer
	assign access   = psel_i & penable_i;
	assign ctrl_hit = (paddr_i == `AM_REG_CTRL);

	// Write data with the reserved bits forced low
	always_comb begin
		wr_word.raw        = pwdata_i;
		wr_word.f.reserved = '0;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			ctrl_q.raw <= '0;
		end else if (access && pwrite_i && ctrl_hit) begin
			ctrl_q <= wr_word;
		end
	end

	//================================================
	// APB response
	//================================================
	assign pready_o  = 1'b1;
	assign pslverr_o = access & ~ctrl_hit;
	assign prdata_o  = (psel_i && !pwrite_i && ctrl_hit) ? ctrl_q.raw : '0;

	// Field view towards the datapath
	assign cfg.opl_en         = ctrl_q.f.opl_en;
	assign cfg.tape_snd_en    = ctrl_q.f.tape_snd_en;
	assign cfg.right_sid_8580 = ctrl_q.f.right_sid_8580;
	assign cfg.stereo_mix     = ctrl_q.f.stereo_mix;

endmodule

`default_nettype wire

// ==== hw/mix_if.sv ====
//================================================
// Audio mixer interfaces
// Configuration fan-out and per-channel samples
//================================================
`timescale 1ns/1ps
`default_nettype none

`include "audio_mix_config.svh"

// Control fields from the register block
interface mix_cfg_if;
	import audio_mix_pkg::*;

	logic         opl_en;
	logic         tape_snd_en;
	logic         right_sid_8580;
	stereo_mode_t stereo_mix;

	modport regs (output opl_en, output tape_snd_en,
		output right_sid_8580, output stereo_mix);
	modport chan (input opl_en, input tape_snd_en);
	modport cap  (input right_sid_8580);
	modport out  (input stereo_mix);

endinterface

// One captured sample set for a single channel
interface chan_sample_if;

	logic                        valid;
	logic signed [`AM_SID_W-1:0] sid;
	logic signed [`AM_OPL_W-1:0] opl;
	logic                        cass;

	modport src (output valid, output sid, output opl, output cass);
	modport dst (input valid, input sid, input opl, input cass);

endinterface

`default_nettype wire

// ==== hw/audio_mix_pkg.sv ====
//================================================
// Audio mixer types
// Stereo blend modes and the control register word
//================================================
`default_nettype none

`include "audio_mix_config.svh"

package audio_mix_pkg;

	// Stereo blend, matches the 2-bit mode field
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} stereo_mode_t;

	// CTRL register fields, MSB first
	typedef struct packed {
		logic [`AM_DATA_W-6:0] reserved;
		stereo_mode_t          stereo_mix;
		logic                  right_sid_8580;
		logic                  tape_snd_en;
		logic                  opl_en;
	} mix_ctrl_t;

	// APB side sees the raw word, mixer side the fields
	typedef union packed {
		logic [`AM_DATA_W-1:0] raw;
		mix_ctrl_t             f;
	} mix_ctrl_u;

endpackage

`default_nettype wire

// ==== include/audio_mix_config.svh ====
//================================================
// Audio mixer configuration
// Sample widths, channel count, register map and
// the cassette sound level
//================================================
`ifndef AUDIO_MIX_CONFIG_SVH
`define AUDIO_MIX_CONFIG_SVH

// Sample widths
`define AM_SID_W       18
`define AM_OPL_W       16
`define AM_OUT_W       16

// Left and right
`define AM_NUM_CH      2

// APB register port
`define AM_APB_AW      4
`define AM_DATA_W      32
`define AM_REG_CTRL    4'h0

// Level added while the cassette bit is high
`define AM_TAPE_LEVEL  1024

`endif
